/* sources.f */
+incdir+tests
logic/moxie_pkg.sv
logic/moxie_regfile.sv
logic/moxie_issue.sv
logic/moxie_execute.sv
logic/moxie_core.sv
tests/tb_moxie_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module tb_moxie_core -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* tests/tb_moxie_model.svh */
// ******************************
// Reference model, stepped once per accepted instruction
// Branch target uses the low 10 immediate bits as a halfword offset
// ******************************

word_t    m_regs [16];
cc_t      m_cc;
word_t    m_pc;
logic     m_pending;
reg_idx_t q_ret_idx [$];
word_t    q_ret_data [$];
word_t    q_mem_addr [$];
word_t    q_mem_data [$];
word_t    q_redir [$];

task automatic clear_state();
  m_regs    = '{default: '0};
  m_cc      = '0;
  m_pc      = PC_RESET;
  m_pending = 1'b0;
endtask

task automatic retire_reg(input reg_idx_t idx, input word_t val);
  q_ret_idx.push_back(idx);
  q_ret_data.push_back(val);
  m_regs[idx] = val;
endtask

task automatic emit_store(input word_t addr, input word_t data);
  q_mem_addr.push_back(addr);
  q_mem_data.push_back(data);
endtask

// Everything fetched after this is off-path until the target arrives
task automatic take_branch(input word_t target);
  q_redir.push_back(target);
  m_pc      = target;
  m_pending = 1'b1;
endtask

task automatic run_instr(input op_t op, input reg_idx_t ra, input reg_idx_t rb,
                         input word_t imm, input word_t pc);
  word_t a;
  word_t b;
  word_t sp;
  word_t nxt;
  word_t off;
  logic  hit;
  if (pc != m_pc)
  begin
    return;
  end
  a   = m_regs[ra];
  b   = m_regs[rb];
  sp  = m_regs[REG_SP];
  off = {{22{imm[9]}}, imm[9:0]};
  hit = 1'b0;
  nxt = pc + ((op == OP_JSRA || op == OP_JMPA || op == OP_LDI || op == OP_STA) ?
              32'd6 : 32'd2);
  m_pc = nxt;
  case (op)
    OP_ADD:  retire_reg(ra, a + b);
    OP_SUB:  retire_reg(ra, a - b);
    OP_AND:  retire_reg(ra, a & b);
    OP_OR:   retire_reg(ra, a | b);
    OP_XOR:  retire_reg(ra, a ^ b);
    OP_ASHL: retire_reg(ra, a << b[4:0]);
    OP_ASHR: retire_reg(ra, $signed(a) >>> b[4:0]);
    OP_LSHR: retire_reg(ra, a >> b[4:0]);
    OP_NEG:  retire_reg(ra, -b);
    OP_NOT:  retire_reg(ra, ~b);
    OP_MOV:  retire_reg(ra, b);
    OP_INC:  retire_reg(ra, a + imm);
    OP_DEC:  retire_reg(ra, a - imm);
    OP_LDI:  retire_reg(ra, imm);
    OP_CMP:
    begin
      m_cc.eq  = (a == b);
      m_cc.lt  = ($signed(a) < $signed(b));
      m_cc.gt  = ($signed(a) > $signed(b));
      m_cc.ltu = (a < b);
      m_cc.gtu = (a > b);
    end
    OP_BEQ:  hit = m_cc.eq;
    OP_BNE:  hit = ~m_cc.eq;
    OP_BLT:  hit = m_cc.lt;
    OP_BGT:  hit = m_cc.gt;
    OP_BLTU: hit = m_cc.ltu;
    OP_BGTU: hit = m_cc.gtu;
    OP_BLE:  hit = m_cc.eq | m_cc.lt;
    OP_BGE:  hit = m_cc.eq | m_cc.gt;
    OP_BLEU: hit = m_cc.eq | m_cc.ltu;
    OP_BGEU: hit = m_cc.eq | m_cc.gtu;
    OP_JMP:  take_branch(a);
    OP_JMPA: take_branch(imm);
    OP_JSR, OP_JSRA:
    begin
      // Return address first, then the caller's frame pointer
      retire_reg(REG_SP, sp - 32'd8);
      emit_store(sp - 32'd8, nxt);
      retire_reg(REG_SP, sp - 32'd12);
      emit_store(sp - 32'd12, m_regs[REG_FP]);
      take_branch((op == OP_JSR) ? a : imm);
    end
    OP_PUSH:
    begin
      retire_reg(ra, a - 32'd4);
      emit_store(a - 32'd4, b);
    end
    OP_STA:  emit_store(imm, a);
    default: ;
  endcase
  if (hit)
  begin
    take_branch(pc + 32'd2 + {off[30:0], 1'b0});
  end
endtask

/* tests/tb_moxie_core.sv */
// ******************************
// Random program from a 32-bit LFSR where fetch follows taken redirects
// ******************************
`timescale 1ns/1ps

module tb_moxie_core
  import moxie_pkg::*;
();

  localparam int NUM_INSTR = 500;
  localparam int LIMIT     = 40 * NUM_INSTR + 100;

  logic     clk_i;
  logic     rst_i;
  logic     instr_valid_i;
  op_t      instr_op_i;
  reg_idx_t instr_ra_i;
  reg_idx_t instr_rb_i;
  word_t    instr_imm_i;
  word_t    instr_pc_i;
  logic     instr_ready_o;
  logic     rf_we_o;
  reg_idx_t rf_idx_o;
  word_t    rf_data_o;
  logic     mem_valid_o;
  word_t    mem_addr_o;
  word_t    mem_data_o;
  logic     mem_ready_i;
  logic     redirect_o;
  word_t    redirect_pc_o;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          sent;

  `include "tb_moxie_model.svh"

  moxie_core DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .instr_ra_i    (instr_ra_i),
    .instr_rb_i    (instr_rb_i),
    .instr_imm_i   (instr_imm_i),
    .instr_pc_i    (instr_pc_i),
    .instr_ready_o (instr_ready_o),
    .rf_we_o       (rf_we_o),
    .rf_idx_o      (rf_idx_o),
    .rf_data_o     (rf_data_o),
    .mem_valid_o   (mem_valid_o),
    .mem_addr_o    (mem_addr_o),
    .mem_data_o    (mem_data_o),
    .mem_ready_i   (mem_ready_i),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, want);
    end
  endtask

  function automatic logic queues_empty();
    return (q_ret_idx.size() == 0) && (q_mem_addr.size() == 0) && (q_redir.size() == 0);
  endfunction

  // Held instructions stay put; a new one is picked only after a transfer
  task automatic drive_inputs(input logic accepted);
    word_t r;
    logic  off_path;
    r = rand_bits(2);
    mem_ready_i = (r != 0);
    if (!instr_valid_i || accepted)
    begin
      r = rand_bits(2);
      if (sent >= NUM_INSTR || r == 0)
      begin
        instr_valid_i = 1'b0;
      end
      else
      begin
        r = rand_bits(9);
        instr_op_i  = op_t'({r[8:5] == 4'd0, r[4:0]});
        r = rand_bits(8);
        instr_ra_i  = r[3:0];
        instr_rb_i  = r[7:4];
        instr_imm_i = rand_bits(32);
        r = rand_bits(3);
        off_path    = m_pending || (r == 0);
        instr_pc_i  = off_path ? (m_pc ^ 32'h0000_0100) : m_pc;
        instr_valid_i = 1'b1;
      end
    end
  endtask

  task automatic sample_outputs();
    if (rf_we_o)
    begin
      if (q_ret_idx.size() == 0)
      begin
        errors++;
        $display("Register write to r%0d when none was expected", rf_idx_o);
      end
      else
      begin
        check_idx("rf_idx_o", rf_idx_o, q_ret_idx.pop_front());
        check_word("rf_data_o", rf_data_o, q_ret_data.pop_front());
      end
    end
    if (mem_valid_o && mem_ready_i)
    begin
      if (q_mem_addr.size() == 0)
      begin
        errors++;
        $display("Memory write to %h when none was expected", mem_addr_o);
      end
      else
      begin
        check_word("mem_addr_o", mem_addr_o, q_mem_addr.pop_front());
        check_word("mem_data_o", mem_data_o, q_mem_data.pop_front());
      end
    end
    if (redirect_o)
    begin
      if (q_redir.size() == 0)
      begin
        errors++;
        $display("Redirect to %h when no branch was taken", redirect_pc_o);
      end
      else
      begin
        check_word("redirect_pc_o", redirect_pc_o, q_redir.pop_front());
      end
      // Fetch may now deliver the target
      m_pending = 1'b0;
    end
  endtask

  initial
  begin
    int   cycles;
    int   tail;
    logic accepted;
    lfsr          = 32'hc514;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    cycles        = 0;
    tail          = 0;
    accepted      = 1'b0;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_op_i    = OP_NOP;
    instr_ra_i    = '0;
    instr_rb_i    = '0;
    instr_imm_i   = '0;
    instr_pc_i    = '0;
    mem_ready_i   = 1'b0;
    clear_state();
    repeat (2) @(posedge clk_i);
    #10;
    check_flag("instr_ready_o", instr_ready_o, 1'b0);
    check_flag("rf_we_o", rf_we_o, 1'b0);
    check_flag("mem_valid_o", mem_valid_o, 1'b0);
    check_flag("redirect_o", redirect_o, 1'b0);
    rst_i = 1'b0;
    while (tail < 4 && cycles < LIMIT)
    begin
      drive_inputs(accepted);
      @(negedge clk_i);
      sample_outputs();
      accepted = instr_valid_i && instr_ready_o;
      if (accepted)
      begin
        sent++;
        run_instr(instr_op_i, instr_ra_i, instr_rb_i, instr_imm_i, instr_pc_i);
      end
      if (sent >= NUM_INSTR && queues_empty())
      begin
        tail++;
      end
      else
      begin
        tail = 0;
      end
      @(posedge clk_i);
      #10;
      cycles++;
    end
    if (cycles >= LIMIT)
    begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
               cycles, sent, NUM_INSTR);
    end
    if (!queues_empty())
    begin
      errors++;
      $display("Events never seen: %0d register writes, %0d stores, %0d redirects",
               q_ret_idx.size(), q_mem_addr.size(), q_redir.size());
    end
    check_flag("mem_valid_o", mem_valid_o, 1'b0);
    $display("checks %0d errors %0d instructions %0d", checks, errors, sent);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* logic/moxie_core.sv */
// ******************************
// Fetch source must hold its fields while valid is high and ready is low
// ******************************
`timescale 1ns/1ps

module moxie_core
  import moxie_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  op_t      instr_op_i,
  input  reg_idx_t instr_ra_i,
  input  reg_idx_t instr_rb_i,
  input  word_t    instr_imm_i,
  input  word_t    instr_pc_i,
  output logic     instr_ready_o,
  output logic     rf_we_o,
  output reg_idx_t rf_idx_o,
  output word_t    rf_data_o,
  output logic     mem_valid_o,
  output word_t    mem_addr_o,
  output word_t    mem_data_o,
  input  logic     mem_ready_i,
  output logic     redirect_o,
  output word_t    redirect_pc_o
);

  reg_idx_t ra_idx;
  reg_idx_t rb_idx;
  word_t    ra_data;
  word_t    rb_data;
  word_t    sp_data;
  word_t    fp_data;
  logic     ex_valid;
  op_t      ex_op;
  reg_idx_t ex_dst;
  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_sp;
  word_t    ex_fp;
  word_t    ex_imm;
  word_t    ex_pc;
  logic     ex_ready;

  moxie_issue u_issue (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .instr_ra_i    (instr_ra_i),
    .instr_rb_i    (instr_rb_i),
    .instr_imm_i   (instr_imm_i),
    .instr_pc_i    (instr_pc_i),
    .instr_ready_o (instr_ready_o),
    .ra_idx_o      (ra_idx),
    .rb_idx_o      (rb_idx),
    .ra_data_i     (ra_data),
    .rb_data_i     (rb_data),
    .sp_data_i     (sp_data),
    .fp_data_i     (fp_data),
    .wb_we_i       (rf_we_o),
    .wb_idx_i      (rf_idx_o),
    .wb_data_i     (rf_data_o),
    .redirect_i    (redirect_o),
    .redirect_pc_i (redirect_pc_o),
    .ex_valid_o    (ex_valid),
    .ex_op_o       (ex_op),
    .ex_dst_o      (ex_dst),
    .ex_a_o        (ex_a),
    .ex_b_o        (ex_b),
    .ex_sp_o       (ex_sp),
    .ex_fp_o       (ex_fp),
    .ex_imm_o      (ex_imm),
    .ex_pc_o       (ex_pc),
    .ex_ready_i    (ex_ready)
  );

  // Retire port doubles as the register file write port
  moxie_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ra_idx_i  (ra_idx),
    .rb_idx_i  (rb_idx),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data),
    .sp_data_o (sp_data),
    .fp_data_o (fp_data),
    .we_i      (rf_we_o),
    .wr_idx_i  (rf_idx_o),
    .wr_data_i (rf_data_o)
  );

  moxie_execute u_execute (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ex_valid_i    (ex_valid),
    .ex_op_i       (ex_op),
    .ex_dst_i      (ex_dst),
    .ex_a_i        (ex_a),
    .ex_b_i        (ex_b),
    .ex_sp_i       (ex_sp),
    .ex_fp_i       (ex_fp),
    .ex_imm_i      (ex_imm),
    .ex_pc_i       (ex_pc),
    .ex_ready_o    (ex_ready),
    .rf_we_o       (rf_we_o),
    .rf_idx_o      (rf_idx_o),
    .rf_data_o     (rf_data_o),
    .mem_valid_o   (mem_valid_o),
    .mem_addr_o    (mem_addr_o),
    .mem_data_o    (mem_data_o),
    .mem_ready_i   (mem_ready_i),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

/* logic/moxie_execute.sv */
// ******************************
// Memory write beat holds until accepted and the whole stage stalls meanwhile
// Call takes two beats and the redirect comes with the second
// ******************************
`timescale 1ns/1ps

module moxie_execute
  import moxie_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     ex_valid_i,
  input  op_t      ex_op_i,
  input  reg_idx_t ex_dst_i,
  input  word_t    ex_a_i,
  input  word_t    ex_b_i,
  input  word_t    ex_sp_i,
  input  word_t    ex_fp_i,
  input  word_t    ex_imm_i,
  input  word_t    ex_pc_i,
  output logic     ex_ready_o,
  output logic     rf_we_o,
  output reg_idx_t rf_idx_o,
  output word_t    rf_data_o,
  output logic     mem_valid_o,
  output word_t    mem_addr_o,
  output word_t    mem_data_o,
  input  logic     mem_ready_i,
  output logic     redirect_o,
  output word_t    redirect_pc_o
);

  cc_t      cc_q;
  cc_t      cc_new;
  logic     beat2_q;
  word_t    call_tgt_q;
  logic     stall;
  logic     go;
  logic     we;
  reg_idx_t idx;
  word_t    res;
  logic     mem_req;
  word_t    addr;
  word_t    data;
  logic     taken;
  word_t    target;
  word_t    br_tgt;

  assign stall      = mem_valid_o & ~mem_ready_i;
  assign go         = ex_valid_i & ~stall;
  assign ex_ready_o = ~stall & ~(ex_valid_i & is_call(ex_op_i) & ~beat2_q);

  assign cc_new.eq  = ex_a_i == ex_b_i;
  assign cc_new.lt  = $signed(ex_a_i) < $signed(ex_b_i);
  assign cc_new.gt  = $signed(ex_a_i) > $signed(ex_b_i);
  assign cc_new.ltu = ex_a_i < ex_b_i;
  assign cc_new.gtu = ex_a_i > ex_b_i;

  // 10-bit halfword offset from the next instruction
  assign br_tgt = ex_pc_i + 32'd2 + {{21{ex_imm_i[9]}}, ex_imm_i[9:0], 1'b0};

  always_comb
  begin
    we      = 1'b0;
    idx     = ex_dst_i;
    res     = '0;
    mem_req = 1'b0;
    addr    = '0;
    data    = '0;
    taken   = 1'b0;
    target  = br_tgt;
    case (ex_op_i)
      OP_ADD:  begin we = 1'b1; res = ex_a_i + ex_b_i; end
      OP_SUB:  begin we = 1'b1; res = ex_a_i - ex_b_i; end
      OP_AND:  begin we = 1'b1; res = ex_a_i & ex_b_i; end
      OP_OR:   begin we = 1'b1; res = ex_a_i | ex_b_i; end
      OP_XOR:  begin we = 1'b1; res = ex_a_i ^ ex_b_i; end
      OP_ASHL: begin we = 1'b1; res = ex_a_i << ex_b_i[4:0]; end
      OP_ASHR: begin we = 1'b1; res = $signed(ex_a_i) >>> ex_b_i[4:0]; end
      OP_LSHR: begin we = 1'b1; res = ex_a_i >> ex_b_i[4:0]; end
      OP_NEG:  begin we = 1'b1; res = -ex_b_i; end
      OP_NOT:  begin we = 1'b1; res = ~ex_b_i; end
      OP_MOV:  begin we = 1'b1; res = ex_b_i; end
      OP_INC:  begin we = 1'b1; res = ex_a_i + ex_imm_i; end
      OP_DEC:  begin we = 1'b1; res = ex_a_i - ex_imm_i; end
      OP_LDI:  begin we = 1'b1; res = ex_imm_i; end
      OP_BEQ:  taken = cc_q.eq;
      OP_BNE:  taken = ~cc_q.eq;
      OP_BLT:  taken = cc_q.lt;
      OP_BGT:  taken = cc_q.gt;
      OP_BLTU: taken = cc_q.ltu;
      OP_BGTU: taken = cc_q.gtu;
      OP_BLE:  taken = cc_q.eq | cc_q.lt;
      OP_BGE:  taken = cc_q.eq | cc_q.gt;
      OP_BLEU: taken = cc_q.eq | cc_q.ltu;
      OP_BGEU: taken = cc_q.eq | cc_q.gtu;
      OP_JMP:  begin taken = 1'b1; target = ex_a_i; end
      OP_JMPA: begin taken = 1'b1; target = ex_imm_i; end
      OP_JSR, OP_JSRA:
      begin
        we      = 1'b1;
        idx     = REG_SP;
        mem_req = 1'b1;
        if (!beat2_q)
        begin
          // Return address at sp-8
          res  = ex_sp_i - 32'd8;
          data = ex_pc_i + instr_len(ex_op_i);
        end
        else
        begin
          // Frame pointer goes below the sp already moved by 8
          res    = ex_sp_i - 32'd4;
          data   = ex_fp_i;
          taken  = 1'b1;
          target = call_tgt_q;
        end
        addr = res;
      end
      OP_PUSH:
      begin
        we      = 1'b1;
        res     = ex_a_i - 32'd4;
        mem_req = 1'b1;
        addr    = res;
        data    = ex_b_i;
      end
      OP_STA:
      begin
        mem_req = 1'b1;
        addr    = ex_imm_i;
        data    = ex_a_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cc_q        <= '0;
      beat2_q     <= 1'b0;
      rf_we_o     <= 1'b0;
      mem_valid_o <= 1'b0;
      redirect_o  <= 1'b0;
    end
    else
    begin
      rf_we_o    <= go & we;
      redirect_o <= go & taken;
      if (!stall)
      begin
        mem_valid_o <= go & mem_req;
      end
      if (go && ex_op_i == OP_CMP)
      begin
        cc_q <= cc_new;
      end
      if (go && is_call(ex_op_i))
      begin
        beat2_q <= ~beat2_q;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (go && we)
    begin
      rf_idx_o  <= idx;
      rf_data_o <= res;
    end
    if (go && mem_req)
    begin
      mem_addr_o <= addr;
      mem_data_o <= data;
    end
    if (go && taken)
    begin
      redirect_pc_o <= target;
    end
    // Target is fixed before sp changes under the call
    if (go && is_call(ex_op_i) && !beat2_q)
    begin
      call_tgt_q <= (ex_op_i == OP_JSRA) ? ex_imm_i : ex_a_i;
    end
  end

endmodule

/* logic/moxie_issue.sv */
// ******************************
// Drops instructions whose pc is off the expected path
// Holds one instruction; operands keep tracking the write port while held
// ******************************
`timescale 1ns/1ps

module moxie_issue
  import moxie_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  op_t      instr_op_i,
  input  reg_idx_t instr_ra_i,
  input  reg_idx_t instr_rb_i,
  input  word_t    instr_imm_i,
  input  word_t    instr_pc_i,
  output logic     instr_ready_o,
  output reg_idx_t ra_idx_o,
  output reg_idx_t rb_idx_o,
  input  word_t    ra_data_i,
  input  word_t    rb_data_i,
  input  word_t    sp_data_i,
  input  word_t    fp_data_i,
  input  logic     wb_we_i,
  input  reg_idx_t wb_idx_i,
  input  word_t    wb_data_i,
  input  logic     redirect_i,
  input  word_t    redirect_pc_i,
  output logic     ex_valid_o,
  output op_t      ex_op_o,
  output reg_idx_t ex_dst_o,
  output word_t    ex_a_o,
  output word_t    ex_b_o,
  output word_t    ex_sp_o,
  output word_t    ex_fp_o,
  output word_t    ex_imm_o,
  output word_t    ex_pc_o,
  input  logic     ex_ready_i
);

  logic     started_q;
  logic     valid_q;
  word_t    exp_pc_q;
  op_t      op_q;
  reg_idx_t dst_q;
  reg_idx_t rb_q;
  word_t    a_q;
  word_t    b_q;
  word_t    sp_q;
  word_t    fp_q;
  word_t    imm_q;
  word_t    pc_q;
  logic     load;

  // Take the value being written this cycle when the index matches
  function automatic word_t fwd(input reg_idx_t idx, input word_t val);
    fwd = (wb_we_i && (wb_idx_i == idx)) ? wb_data_i : val;
  endfunction

  assign ra_idx_o = instr_ra_i;
  assign rb_idx_o = instr_rb_i;

  // No new fetch in the cycle after a redirect
  assign instr_ready_o = started_q & ~redirect_i & (~valid_q | ex_ready_i);
  assign load = instr_valid_i & instr_ready_o & (instr_pc_i == exp_pc_q);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      started_q <= 1'b0;
      valid_q   <= 1'b0;
      exp_pc_q  <= PC_RESET;
    end
    else
    begin
      started_q <= 1'b1;
      if (redirect_i)
      begin
        valid_q  <= 1'b0;
        exp_pc_q <= redirect_pc_i;
      end
      else if (load)
      begin
        valid_q  <= 1'b1;
        exp_pc_q <= instr_pc_i + instr_len(instr_op_i);
      end
      else if (ex_ready_i)
      begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      op_q  <= instr_op_i;
      dst_q <= instr_ra_i;
      rb_q  <= instr_rb_i;
      imm_q <= instr_imm_i;
      pc_q  <= instr_pc_i;
      a_q   <= fwd(instr_ra_i, ra_data_i);
      b_q   <= fwd(instr_rb_i, rb_data_i);
      sp_q  <= fwd(REG_SP, sp_data_i);
      fp_q  <= fwd(REG_FP, fp_data_i);
    end
    else
    begin
      // Held instruction picks up results retired behind it
      a_q  <= ex_a_o;
      b_q  <= ex_b_o;
      sp_q <= ex_sp_o;
      fp_q <= ex_fp_o;
    end
  end

  // The instruction behind a taken redirect is off-path
  assign ex_valid_o = valid_q & ~redirect_i;
  assign ex_op_o    = op_q;
  assign ex_dst_o   = dst_q;
  assign ex_imm_o   = imm_q;
  assign ex_pc_o    = pc_q;
  assign ex_a_o     = fwd(dst_q, a_q);
  assign ex_b_o     = fwd(rb_q, b_q);
  assign ex_sp_o    = fwd(REG_SP, sp_q);
  assign ex_fp_o    = fwd(REG_FP, fp_q);

endmodule

/* logic/moxie_regfile.sv */
// ******************************
// Asynchronous reads, a same-cycle write is not visible until the edge
// ******************************
`timescale 1ns/1ps

module moxie_regfile
  import moxie_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_idx_t ra_idx_i,
  input  reg_idx_t rb_idx_i,
  output word_t    ra_data_o,
  output word_t    rb_data_o,
  output word_t    sp_data_o,
  output word_t    fp_data_o,
  input  logic     we_i,
  input  reg_idx_t wr_idx_i,
  input  word_t    wr_data_i
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we_i)
    begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  assign ra_data_o = regs[ra_idx_i];
  assign rb_data_o = regs[rb_idx_i];

  // Stack and frame pointer taps for the call sequence
  assign sp_data_o = regs[REG_SP];
  assign fp_data_o = regs[REG_FP];

endmodule

/* logic/moxie_pkg.sv */
// ******************************
// Opcode codes are local to this core, not the Moxie byte encoding
// Codes outside op_t execute as a no-op
// ******************************
package moxie_pkg;

  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 4;
  localparam int NUM_REGS  = 16;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Fixed register roles
  localparam reg_idx_t REG_FP = 4'd0;
  localparam reg_idx_t REG_SP = 4'd1;

  localparam word_t PC_RESET = 32'h0000_1000;

  typedef enum logic [5:0] {
    OP_NOP,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_ASHL, OP_ASHR, OP_LSHR,
    OP_NEG, OP_NOT, OP_MOV,
    OP_INC, OP_DEC,
    OP_LDI,
    OP_CMP,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGT, OP_BLTU, OP_BGTU,
    OP_BLE, OP_BGE, OP_BLEU, OP_BGEU,
    OP_JMP, OP_JMPA, OP_JSR, OP_JSRA,
    OP_PUSH, OP_STA
  } op_t;

  // Condition codes with eq in the top bit
  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

  // Byte length of an instruction for fall-through and return addresses
  function automatic word_t instr_len(input op_t op);
    case (op)
      OP_JSRA, OP_JMPA, OP_LDI, OP_STA: instr_len = 32'd6;
      default:                          instr_len = 32'd2;
    endcase
  endfunction

  function automatic logic is_call(input op_t op);
    is_call = (op == OP_JSR) || (op == OP_JSRA);
  endfunction

endpackage
